// File: project.f
+incdir+common
common/id_tracker_pkg.sv
id_tracking/toggle_memory.sv
id_tracking/id_allocator.sv
id_tracking/operand_tracker.sv
hdl/metadata_tables.sv
hdl/instruction_tracker_top.sv
dv/instruction_tracker_tb.sv

// File: dv/instruction_tracker_tb.sv
`timescale 1ns/100ps
`include "id_tracker_consts.svh"

module instruction_tracker_tb;

    localparam int OP_IDLE = 0;
    localparam int OP_ASSIGN = 1;
    localparam int OP_FETCH = 2;
    localparam int OP_DECODE = 3;
    localparam int OP_ISSUE = 4;
    localparam int OP_RETIRE = 5;
    localparam int OP_FLUSH = 6;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic fetch_flush = 1'b0;
    id_tracker_pkg::id_t pc_id;
    logic pc_id_available;
    logic [31:0] if_pc = '0;
    logic pc_id_assigned = 1'b0;
    id_tracker_pkg::id_t fetch_id;
    logic fetch_complete = 1'b0;
    logic [31:0] fetch_instruction = '0;
    logic decode_valid;
    id_tracker_pkg::id_t decode_id;
    logic [31:0] decode_pc;
    logic [31:0] decode_instruction;
    logic decode_advance = 1'b0;
    logic instruction_issued = 1'b0;
    logic issue_stage_valid = 1'b0;
    id_tracker_pkg::id_t issue_id = '0;
    logic issue_uses_rd = 1'b0;
    logic [4:0] issue_rd_addr = '0;
    logic [4:0] issue_rs_addr [`READ_PORTS] = '{default: '0};
    id_tracker_pkg::id_t rs_id [`READ_PORTS];
    logic rs_inuse [`READ_PORTS];
    logic rs_id_inuse [`READ_PORTS];
    logic retired [`COMMIT_PORTS] = '{default: 1'b0};
    id_tracker_pkg::id_t ids_retiring [`COMMIT_PORTS] = '{default: '0};
    logic nonrd_complete = 1'b0;
    id_tracker_pkg::id_t nonrd_id = '0;
    logic [`COMPLETE_W-1:0] retire_inc;
    logic [4:0] retired_rd_addr [`COMMIT_PORTS];
    id_tracker_pkg::id_t id_for_rd [`COMMIT_PORTS];
    logic [31:0] exception_pc;

    instruction_tracker_top dut0 (.*);

    always #2 clk = ~clk;

    ////////////////////
    // Stimulus table and reference model

    int tbl_op[$];
    int tbl_a[$];
    int tbl_b[$];
    int errors = 0;
    logic [31:0] lfsr_state = 32'h77e5;

    id_tracker_pkg::id_t m_pc_id = '0;
    id_tracker_pkg::id_t m_fetch_id = '0;
    id_tracker_pkg::id_t m_decode_id = '0;
    int m_pending = 0;
    int m_to_fetch = 0;
    int m_fetched = 0;
    logic m_avail = 1'b1;
    logic [`COMPLETE_W-1:0] m_inc = '0;
    logic [31:0] m_pc_tbl [`MAX_IDS];
    logic [31:0] m_instr_tbl [`MAX_IDS];
    logic [4:0] m_rd_tbl [`MAX_IDS];
    bit m_dec_not_issued [`MAX_IDS];
    bit m_inflight [`MAX_IDS];
    bit m_writer_inflight [`MAX_IDS];
    id_tracker_pkg::id_t m_writer [32] = '{default: '0};
    bit m_writer_known [32];
    id_tracker_pkg::id_t issue_q[$];
    id_tracker_pkg::id_t done_q[$];

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic add_row(input int op, input int a = 0, input int b = 0);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
    endtask

    ////////////////////
    // Compare tasks

    task automatic check_id(input string name, input id_tracker_pkg::id_t exp,
                            input id_tracker_pkg::id_t act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [`COMPLETE_W-1:0] exp,
                               input logic [`COMPLETE_W-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    ////////////////////
    // One table row per clock

    task automatic run_row(input int row, input int op, input int a, input int b);
        id_tracker_pkg::id_t id;
        id_tracker_pkg::instr_word_u w;
        logic [4:0] rs;
        bit busy [`MAX_IDS];
        int pend_start;
        int assign_now;
        int port;
        bit nonrd_used;
        bit stop;
        string tag;
        @(negedge clk);
        tag = $sformatf("row %0d", row);
        pc_id_assigned = 0;
        fetch_complete = 0;
        decode_advance = 0;
        instruction_issued = 0;
        fetch_flush = 0;
        nonrd_complete = 0;
        retired = '{default: 1'b0};
        // Oldest decoded ID waits in issue
        issue_stage_valid = issue_q.size() > 0;
        // Registered state from the previous row
        check_id({tag, " pc_id"}, m_pc_id, pc_id);
        check_id({tag, " fetch_id"}, m_fetch_id, fetch_id);
        check_id({tag, " decode_id"}, m_decode_id, decode_id);
        check_bit({tag, " pc_id_available"}, m_avail, pc_id_available);
        check_bit({tag, " decode_valid"}, m_fetched != 0, decode_valid);
        check_count({tag, " retire_inc"}, m_inc, retire_inc);
        for (int i = 0; i < `MAX_IDS; i++) begin
            busy[i] = m_dec_not_issued[i] | m_inflight[i];
        end
        pend_start = m_pending;
        assign_now = 0;
        port = 0;
        nonrd_used = 0;
        case (op)
            OP_ASSIGN: if (m_avail) begin
                if_pc = lfsr_bits(30) << 2;
                pc_id_assigned = 1;
                m_pc_tbl[m_pc_id] = if_pc;
                m_pc_id++;
                m_pending++;
                m_to_fetch++;
                assign_now = 1;
            end
            OP_FETCH: if (m_to_fetch > 0) begin
                w.raw = lfsr_bits(32);
                w.fields.rd = a[4:0];
                fetch_instruction = w.raw;
                fetch_complete = 1;
                m_instr_tbl[m_fetch_id] = w.raw;
                m_rd_tbl[m_fetch_id] = a[4:0];
                m_fetch_id++;
                m_to_fetch--;
                m_fetched++;
            end
            OP_DECODE: if (m_fetched > 0) begin
                decode_advance = 1;
                #1;
                check_word({tag, " decode_pc"}, m_pc_tbl[m_decode_id], decode_pc);
                check_word({tag, " decode_instruction"}, m_instr_tbl[m_decode_id],
                           decode_instruction);
                m_dec_not_issued[m_decode_id] = 1;
                issue_q.push_back(m_decode_id);
                m_decode_id++;
                m_fetched--;
                m_pending--;
            end
            OP_ISSUE: if (issue_q.size() > 0) begin
                id = issue_q.pop_front();
                instruction_issued = 1;
                issue_id = id;
                issue_uses_rd = m_rd_tbl[id] != 0;
                issue_rd_addr = m_rd_tbl[id];
                issue_rs_addr[0] = a[4:0];
                issue_rs_addr[1] = b[4:0];
                #1;
                for (int r = 0; r < `READ_PORTS; r++) begin
                    rs = issue_rs_addr[r];
                    check_id({tag, " rs_id"}, m_writer[rs], rs_id[r]);
                    check_bit({tag, " rs_id_inuse"},
                              rs != 0 && m_writer_inflight[m_writer[rs]], rs_id_inuse[r]);
                    if (rs == 0 || m_writer_known[rs]) begin
                        check_bit({tag, " rs_inuse"},
                                  rs != 0 && m_rd_tbl[m_writer[rs]] == rs, rs_inuse[r]);
                    end
                end
                m_dec_not_issued[id] = 0;
                m_inflight[id] = 1;
                done_q.push_back(id);
                if (issue_uses_rd) begin
                    m_writer[issue_rd_addr] = id;
                    m_writer_known[issue_rd_addr] = 1;
                    m_writer_inflight[id] = 1;
                end
            end
            OP_RETIRE: begin
                stop = 0;
                // Oldest first; writers on the retire ports, others on nonrd
                for (int k = 0; k < a && !stop && done_q.size() > 0; k++) begin
                    id = done_q[0];
                    if (m_rd_tbl[id] != 0 && port < `COMMIT_PORTS) begin
                        retired[port] = 1;
                        ids_retiring[port] = id;
                        port++;
                        void'(done_q.pop_front());
                    end else if (m_rd_tbl[id] == 0 && !nonrd_used) begin
                        nonrd_complete = 1;
                        nonrd_id = id;
                        nonrd_used = 1;
                        void'(done_q.pop_front());
                    end else begin
                        stop = 1;
                    end
                end
                #1;
                for (int p = 0; p < port; p++) begin
                    id = ids_retiring[p];
                    check_word({tag, " retired_rd_addr"}, 32'(m_rd_tbl[id]),
                               32'(retired_rd_addr[p]));
                    check_id({tag, " id_for_rd"}, m_writer[m_rd_tbl[id]], id_for_rd[p]);
                    m_inflight[id] = 0;
                    m_writer_inflight[id] = 0;
                end
                if (nonrd_used) begin
                    check_word({tag, " exception_pc"}, m_pc_tbl[nonrd_id], exception_pc);
                    m_inflight[nonrd_id] = 0;
                end
            end
            OP_FLUSH: begin
                fetch_flush = 1;
                // A held instruction leaves issue with the flush
                if (issue_q.size() > 0) begin
                    id = issue_q.pop_front();
                    issue_id = id;
                    m_dec_not_issued[id] = 0;
                end
                m_pc_id = m_decode_id;
                m_fetch_id = m_decode_id;
                m_pending = 0;
                m_to_fetch = 0;
                m_fetched = 0;
            end
            default: ;
        endcase
        m_inc = `COMPLETE_W'(port + int'(nonrd_used));
        // Availability looks at toggle state from before this clock
        m_avail = !busy[m_pc_id]
            && (op == OP_FLUSH || pend_start + assign_now < `MAX_IDS);
    endtask

    task automatic build_table();
        int fetch_rd [8] = '{5, 6, 0, 5, 7, 0, 3, 4};
        repeat (9) add_row(OP_ASSIGN);
        foreach (fetch_rd[i]) add_row(OP_FETCH, fetch_rd[i]);
        add_row(OP_DECODE);
        add_row(OP_ASSIGN);
        add_row(OP_ISSUE, 1, 2);
        add_row(OP_DECODE);
        add_row(OP_ISSUE, 5, 6);
        add_row(OP_RETIRE, 1);
        add_row(OP_ASSIGN);
        add_row(OP_ASSIGN);
        add_row(OP_DECODE);
        add_row(OP_ISSUE, 5, 0);
        add_row(OP_DECODE);
        add_row(OP_ISSUE, 6, 5);
        add_row(OP_RETIRE, 2);
        add_row(OP_RETIRE, 1);
        add_row(OP_DECODE);
        add_row(OP_ISSUE, 7, 0);
        add_row(OP_DECODE);
        add_row(OP_ISSUE, 0, 7);
        add_row(OP_DECODE);
        add_row(OP_ISSUE, 7, 3);
        add_row(OP_RETIRE, 3);
        add_row(OP_RETIRE, 1);
        add_row(OP_FETCH, 2);
        repeat (2) add_row(OP_ASSIGN);
        add_row(OP_FETCH, 9);
        add_row(OP_DECODE);
        add_row(OP_FLUSH);
        add_row(OP_ASSIGN);
        add_row(OP_FETCH, 4);
        add_row(OP_DECODE);
        add_row(OP_ISSUE, 3, 4);
        add_row(OP_DECODE);
        add_row(OP_RETIRE, 1);
        add_row(OP_ASSIGN);
        repeat (2) add_row(OP_IDLE);
    endtask

    ////////////////////
    // Main sequence and watchdog

    initial begin
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 0;
        foreach (tbl_op[i]) begin
            run_row(i, tbl_op[i], tbl_a[i], tbl_b[i]);
        end
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (tbl_op.size() > 0);
        #(tbl_op.size() * 20 * 4);
        $display("Watchdog expired before the table finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: hdl/instruction_tracker_top.sv
`timescale 1ns/100ps
`include "id_tracker_consts.svh"

module instruction_tracker_top (
    input logic clk,
    input logic rst,
    input logic fetch_flush,

    // Fetch
    output id_tracker_pkg::id_t pc_id,
    output logic pc_id_available,
    input logic [31:0] if_pc,
    input logic pc_id_assigned,
    output id_tracker_pkg::id_t fetch_id,
    input logic fetch_complete,
    input logic [31:0] fetch_instruction,

    // Decode
    output logic decode_valid,
    output id_tracker_pkg::id_t decode_id,
    output logic [31:0] decode_pc,
    output logic [31:0] decode_instruction,
    input logic decode_advance,

    // Issue
    input logic instruction_issued,
    input logic issue_stage_valid,
    input id_tracker_pkg::id_t issue_id,
    input logic issue_uses_rd,
    input logic [4:0] issue_rd_addr,
    input logic [4:0] issue_rs_addr [`READ_PORTS],
    output id_tracker_pkg::id_t rs_id [`READ_PORTS],
    output logic rs_inuse [`READ_PORTS],
    output logic rs_id_inuse [`READ_PORTS],

    // Completion and writeback
    input logic retired [`COMMIT_PORTS],
    input id_tracker_pkg::id_t ids_retiring [`COMMIT_PORTS],
    input logic nonrd_complete,
    input id_tracker_pkg::id_t nonrd_id,
    output logic [`COMPLETE_W-1:0] retire_inc,
    output logic [4:0] retired_rd_addr [`COMMIT_PORTS],
    output id_tracker_pkg::id_t id_for_rd [`COMMIT_PORTS],
    output logic [31:0] exception_pc
);

    // rd of each operand's last writer, from the rd table
    logic [4:0] rd_of_id [`READ_PORTS];

    id_allocator allocator0 (
        .clk, .rst, .fetch_flush, .pc_id_assigned, .fetch_complete, .decode_advance,
        .instruction_issued, .issue_stage_valid, .issue_id, .retired, .ids_retiring,
        .nonrd_complete, .nonrd_id, .pc_id, .fetch_id, .decode_id, .pc_id_available,
        .decode_valid
    );

    operand_tracker operands0 (
        .clk, .rst, .instruction_issued, .issue_id, .issue_uses_rd, .issue_rd_addr,
        .issue_rs_addr, .retired, .ids_retiring, .retired_rd_addr, .rd_of_id,
        .rs_id, .rs_inuse, .rs_id_inuse, .id_for_rd
    );

    metadata_tables tables0 (
        .clk, .pc_id_assigned, .pc_id, .if_pc, .fetch_complete, .fetch_id,
        .fetch_instruction, .decode_id, .ids_retiring, .rs_id, .retired,
        .nonrd_complete, .nonrd_id, .decode_pc, .decode_instruction,
        .retired_rd_addr, .rd_of_id, .exception_pc, .retire_inc
    );

endmodule

// File: hdl/metadata_tables.sv
`timescale 1ns/100ps
`include "id_tracker_consts.svh"

module metadata_tables (
    input logic clk,
    input logic pc_id_assigned,
    input id_tracker_pkg::id_t pc_id,
    input logic [31:0] if_pc,
    input logic fetch_complete,
    input id_tracker_pkg::id_t fetch_id,
    input logic [31:0] fetch_instruction,
    input id_tracker_pkg::id_t decode_id,
    input id_tracker_pkg::id_t ids_retiring [`COMMIT_PORTS],
    input id_tracker_pkg::id_t rs_id [`READ_PORTS],
    input logic retired [`COMMIT_PORTS],
    input logic nonrd_complete,
    input id_tracker_pkg::id_t nonrd_id,
    output logic [31:0] decode_pc,
    output logic [31:0] decode_instruction,
    output logic [4:0] retired_rd_addr [`COMMIT_PORTS],
    output logic [4:0] rd_of_id [`READ_PORTS],
    output logic [31:0] exception_pc,
    output logic [`COMPLETE_W-1:0] retire_inc
);

    logic [31:0] pc_table [`MAX_IDS];
    logic [31:0] instruction_table [`MAX_IDS];
    logic [4:0] rd_table [`MAX_IDS];

    id_tracker_pkg::instr_word_u fetch_word;
    logic [`COMPLETE_W-1:0] complete_count;

    ////////////////////
    // Table writes

    always_ff @(posedge clk) begin
        if (pc_id_assigned) begin
            pc_table[pc_id] <= if_pc;
        end
    end

    assign fetch_word.raw = fetch_instruction;

    always_ff @(posedge clk) begin
        if (fetch_complete) begin
            instruction_table[fetch_id] <= fetch_word.raw;
            rd_table[fetch_id] <= fetch_word.fields.rd;
        end
    end

    ////////////////////
    // Table reads

    assign decode_pc = pc_table[decode_id];
    assign decode_instruction = instruction_table[decode_id];

    // Trap handling needs the PC of the completing non-rd op
    assign exception_pc = pc_table[nonrd_id];

    always_comb begin
        for (int p = 0; p < `COMMIT_PORTS; p++) begin
            retired_rd_addr[p] = rd_table[ids_retiring[p]];
        end
        for (int r = 0; r < `READ_PORTS; r++) begin
            rd_of_id[r] = rd_table[rs_id[r]];
        end
    end

    // Completions this cycle, reported one cycle later
    always_comb begin
        complete_count = `COMPLETE_W'(nonrd_complete);
        for (int p = 0; p < `COMMIT_PORTS; p++) begin
            complete_count = complete_count + `COMPLETE_W'(retired[p]);
        end
    end

    always_ff @(posedge clk) begin
        retire_inc <= complete_count;
    end

endmodule

// File: id_tracking/operand_tracker.sv
`timescale 1ns/100ps
`include "id_tracker_consts.svh"

module operand_tracker (
    input logic clk,
    input logic rst,
    input logic instruction_issued,
    input id_tracker_pkg::id_t issue_id,
    input logic issue_uses_rd,
    input logic [4:0] issue_rd_addr,
    input logic [4:0] issue_rs_addr [`READ_PORTS],
    input logic retired [`COMMIT_PORTS],
    input id_tracker_pkg::id_t ids_retiring [`COMMIT_PORTS],
    input logic [4:0] retired_rd_addr [`COMMIT_PORTS],
    input logic [4:0] rd_of_id [`READ_PORTS],
    output id_tracker_pkg::id_t rs_id [`READ_PORTS],
    output logic rs_inuse [`READ_PORTS],
    output logic rs_id_inuse [`READ_PORTS],
    output id_tracker_pkg::id_t id_for_rd [`COMMIT_PORTS]
);

    logic writer_issue;
    logic issued_status_rs [`READ_PORTS];
    logic [`COMMIT_PORTS-1:0] retired_status_rs [`READ_PORTS];
    logic [`MAX_IDS-1:0] writer_pending;

    // Most recent issued writer of each register
    id_tracker_pkg::id_t rd_to_id_table [32] = '{default: '0};

    assign writer_issue = instruction_issued & issue_uses_rd;

    // x0 never gets a writer entry
    always_ff @(posedge clk) begin
        if (writer_issue && (issue_rd_addr != 5'd0)) begin
            rd_to_id_table[issue_rd_addr] <= issue_id;
        end
    end

    ////////////////////
    // Per-operand status

    for (genvar r = 0; r < `READ_PORTS; r++) begin : g_read
        toggle_memory issued_mem (
            .clk, .rst,
            .toggle(writer_issue),
            .toggle_id(issue_id),
            .read_id(rs_id[r]),
            .read_data(issued_status_rs[r])
        );

        for (genvar p = 0; p < `COMMIT_PORTS; p++) begin : g_commit
            toggle_memory retired_mem (
                .clk, .rst,
                .toggle(retired[p]),
                .toggle_id(ids_retiring[p]),
                .read_id(rs_id[r]),
                .read_data(retired_status_rs[r][p])
            );
        end
    end

    // Only register writers sit in the table, so non-rd completions are ignored
    always_comb begin
        for (int r = 0; r < `READ_PORTS; r++) begin
            rs_id[r] = rd_to_id_table[issue_rs_addr[r]];
            rs_inuse[r] = (|issue_rs_addr[r]) & (issue_rs_addr[r] == rd_of_id[r]);
            rs_id_inuse[r] = (|issue_rs_addr[r])
                & (issued_status_rs[r] ^ (^retired_status_rs[r]));
        end
    end

    // Writeback checks whether the retiring ID is still the register's owner
    always_comb begin
        for (int p = 0; p < `COMMIT_PORTS; p++) begin
            id_for_rd[p] = rd_to_id_table[retired_rd_addr[p]];
        end
    end

    ////////////////////
    // Assertions

    // Writers issued and not yet retired
    always_ff @(posedge clk) begin
        if (rst) begin
            writer_pending <= '0;
        end else begin
            for (int p = 0; p < `COMMIT_PORTS; p++) begin
                if (retired[p]) begin
                    writer_pending[ids_retiring[p]] <= 1'b0;
                end
            end
            if (writer_issue) begin
                writer_pending[issue_id] <= 1'b1;
            end
        end
    end

    writer_reissued_assertion:
        assert property (@(posedge clk) disable iff (rst)
            writer_issue |-> !writer_pending[issue_id])
        else $error("Register writer ID issued again before retiring");

endmodule

// File: id_tracking/id_allocator.sv
`timescale 1ns/100ps
`include "id_tracker_consts.svh"

module id_allocator (
    input logic clk,
    input logic rst,
    input logic fetch_flush,
    input logic pc_id_assigned,
    input logic fetch_complete,
    input logic decode_advance,
    input logic instruction_issued,
    input logic issue_stage_valid,
    input id_tracker_pkg::id_t issue_id,
    input logic retired [`COMMIT_PORTS],
    input id_tracker_pkg::id_t ids_retiring [`COMMIT_PORTS],
    input logic nonrd_complete,
    input id_tracker_pkg::id_t nonrd_id,
    output id_tracker_pkg::id_t pc_id,
    output id_tracker_pkg::id_t fetch_id,
    output id_tracker_pkg::id_t decode_id,
    output logic pc_id_available,
    output logic decode_valid
);

    localparam int CNT_W = `ID_W + 1;

    id_tracker_pkg::id_t pc_id_next;
    logic decode_step;
    logic [CNT_W-1:0] fetched_count;
    logic [CNT_W-1:0] assigned_count;
    logic [CNT_W-1:0] assigned_total;
    logic pool_wrapped;

    logic decoded_status;
    logic decoded_issued_status;
    logic issued_status;
    logic nonrd_status;
    logic [`COMMIT_PORTS-1:0] retired_status;
    logic id_not_in_decode_issue;
    logic id_not_inflight;

    ////////////////////
    // ID counters

    // A flush drops everything not yet decoded
    assign decode_step = decode_advance & ~fetch_flush;
    assign pc_id_next = (fetch_flush ? decode_id : pc_id)
        + id_tracker_pkg::id_t'(pc_id_assigned & ~fetch_flush);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id <= '0;
            fetch_id <= '0;
            decode_id <= '0;
        end else begin
            pc_id <= pc_id_next;
            fetch_id <= (fetch_flush ? decode_id : fetch_id)
                + id_tracker_pkg::id_t'(fetch_complete & ~fetch_flush);
            decode_id <= decode_id + id_tracker_pkg::id_t'(decode_step);
        end
    end

    // Fetched but not yet decoded
    always_ff @(posedge clk) begin
        if (rst | fetch_flush) begin
            fetched_count <= '0;
        end else begin
            fetched_count <= fetched_count + CNT_W'(fetch_complete) - CNT_W'(decode_advance);
        end
    end

    assign decode_valid = |fetched_count;

    // Assigned but not yet decoded; these IDs have no toggle-memory trace
    always_ff @(posedge clk) begin
        if (rst | fetch_flush) begin
            assigned_count <= '0;
        end else begin
            assigned_count <= assigned_count + CNT_W'(pc_id_assigned) - CNT_W'(decode_advance);
        end
    end

    // Whole pool ahead of decode, so the next ID wraps onto one still pending
    assign assigned_total = assigned_count + CNT_W'(pc_id_assigned);
    assign pool_wrapped = ~fetch_flush & (assigned_total >= CNT_W'(`MAX_IDS));

    ////////////////////
    // Status memories

    // Decoded vs. issued or flushed out of issue
    toggle_memory decoded_mem (
        .clk, .rst,
        .toggle(decode_step),
        .toggle_id(decode_id),
        .read_id(pc_id_next),
        .read_data(decoded_status)
    );

    toggle_memory decoded_issued_mem (
        .clk, .rst,
        .toggle(instruction_issued | (fetch_flush & issue_stage_valid)),
        .toggle_id(issue_id),
        .read_id(pc_id_next),
        .read_data(decoded_issued_status)
    );

    // Issued vs. completed through any single source
    toggle_memory issued_mem (
        .clk, .rst,
        .toggle(instruction_issued),
        .toggle_id(issue_id),
        .read_id(pc_id_next),
        .read_data(issued_status)
    );

    for (genvar p = 0; p < `COMMIT_PORTS; p++) begin : g_retired
        toggle_memory retired_mem (
            .clk, .rst,
            .toggle(retired[p]),
            .toggle_id(ids_retiring[p]),
            .read_id(pc_id_next),
            .read_data(retired_status[p])
        );
    end

    toggle_memory nonrd_mem (
        .clk, .rst,
        .toggle(nonrd_complete),
        .toggle_id(nonrd_id),
        .read_id(pc_id_next),
        .read_data(nonrd_status)
    );

    assign id_not_in_decode_issue = ~(decoded_status ^ decoded_issued_status);
    assign id_not_inflight = ~(issued_status ^ (^retired_status) ^ nonrd_status);

    // Looks one ID ahead, so the flag matches what pc_id will offer
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id_available <= 1'b1;
        end else begin
            pc_id_available <= id_not_in_decode_issue & id_not_inflight & ~pool_wrapped;
        end
    end

    ////////////////////
    // Assertions

    pc_id_assigned_when_unavailable_assertion:
        assert property (@(posedge clk) disable iff (rst)
            !(pc_id_assigned & ~pc_id_available))
        else $error("ID assigned while none available");

    decode_advance_without_valid_assertion:
        assert property (@(posedge clk) disable iff (rst)
            !(decode_advance & ~decode_valid))
        else $error("Decode advanced with no fetched instruction");

endmodule

// File: id_tracking/toggle_memory.sv
`timescale 1ns/100ps
`include "id_tracker_consts.svh"

module toggle_memory (
    input logic clk,
    input logic rst,
    input logic toggle,
    input id_tracker_pkg::id_t toggle_id,
    input id_tracker_pkg::id_t read_id,
    output logic read_data
);

    // One status bit per ID, all clear at start of run
    logic id_bits [`MAX_IDS] = '{default: 1'b0};

    always_ff @(posedge clk) begin
        if (toggle) begin
            id_bits[toggle_id] <= ~id_bits[toggle_id];
        end
    end

    // Asynchronous read, new value visible the cycle after a toggle
    assign read_data = id_bits[read_id];

    ////////////////////
    // Assertions

    // Strobes from the other blocks always carry a real ID
    toggle_id_known_assertion:
        assert property (@(posedge clk) disable iff (rst)
            toggle |-> !$isunknown(toggle_id))
        else $error("Toggle strobe with unknown ID");

endmodule

// File: common/id_tracker_pkg.sv
`include "id_tracker_consts.svh"

package id_tracker_pkg;

    ////////////////////
    // Instruction ID

    typedef logic [`ID_W-1:0] id_t;

    ////////////////////
    // Instruction word

    // Raw 32-bit word, or the register fields of an R-type layout
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } fields;
    } instr_word_u;

endpackage

// File: common/id_tracker_consts.svh
`ifndef ID_TRACKER_CONSTS_SVH
`define ID_TRACKER_CONSTS_SVH

////////////////////
// ID pool

// Number of instruction IDs, a power of two
`define MAX_IDS 8
// log2 of MAX_IDS
`define ID_W 3

////////////////////
// Port counts

// Register source operands checked at issue
`define READ_PORTS 2
// Retire ports that write the register file
`define COMMIT_PORTS 2
// Holds COMMIT_PORTS plus the non-rd completion
`define COMPLETE_W 2

`endif
